// File: verilog/filter_pkg.sv
// Shared sizes, encodings and packet/config types for the condition-filter stage
// Compiled first and imported by every RTL file and the testbench
package filter_pkg;

  // --------------------
  // Sizes
  localparam int NUM_FIELDS     = 4;
  localparam int FIELD_W        = 32;
  localparam int NUM_LANES      = 4;
  localparam int LANE_W         = 2;
  localparam int KERNEL_LATENCY = 3;

  // Wide enough for every packet a lane can hold between in_valid and res_valid
  localparam int INFLIGHT_W     = $clog2(KERNEL_LATENCY + 2);

  // --------------------
  // Encodings
  typedef enum logic [1:0] {
    SEQUENCE_INVALID = 2'd0,
    SEQUENCE_RUNNING = 2'd1,
    SEQUENCE_DONE    = 2'd2
  } field_state_e;

  // Codes 9 to 15 are undefined and pass the original copy through
  typedef enum logic [3:0] {
    FILTER_NOP         = 4'd0,
    FILTER_GT          = 4'd1,
    FILTER_LT          = 4'd2,
    FILTER_EQ          = 4'd3,
    FILTER_NOT_EQ      = 4'd4,
    FILTER_GT_TERN     = 4'd5,
    FILTER_LT_TERN     = 4'd6,
    FILTER_EQ_TERN     = 4'd7,
    FILTER_NOT_EQ_TERN = 4'd8
  } filter_op_e;

  // --------------------
  // Packet and lane configuration
  typedef struct packed {
    logic [NUM_FIELDS-1:0][FIELD_W-1:0] field;
    field_state_e [NUM_FIELDS-1:0]      field_state;
  } engine_packet_t;

  // ops_mask[i][j] set means operand slot i takes field j
  typedef struct packed {
    logic [NUM_FIELDS-1:0]                 const_mask;
    logic [NUM_FIELDS-1:0][NUM_FIELDS-1:0] ops_mask;
    logic [FIELD_W-1:0]                    const_value;
    logic [NUM_FIELDS-1:0]                 filter_mask;
    filter_op_e                            filter_operation;
    logic                                  equal_flag;
  } filter_cfg_t;

endpackage : filter_pkg

// File: verilog/filter_lane_if.sv
// Connection bundle for one filter lane, from the dispatcher through a kernel to the collector
// Instantiated once per lane at the top level
`timescale 1ns/1ps

interface filter_lane_if;
  import filter_pkg::*;

  // Dispatcher side
  logic           pkt_valid;
  engine_packet_t pkt;
  filter_cfg_t    cfg;

  // Kernel result side
  logic           res_valid;
  engine_packet_t res;
  logic           res_pass;

  modport feed (
    output pkt_valid,
    output pkt,
    output cfg
  );

  modport kernel (
    input  pkt_valid,
    input  pkt,
    input  cfg,
    output res_valid,
    output res,
    output res_pass
  );

  modport drain (
    input res_valid,
    input res,
    input res_pass
  );

endinterface : filter_lane_if

// File: verilog/filter_dispatch.sv
// Per-lane configuration bank and input packet router
// A packet is registered once and shows up on the lane named by in_lane a cycle later
`timescale 1ns/1ps

module filter_dispatch (
  input  logic                        ap_clk,
  input  logic                        rst_n,
  input  logic                        cfg_wr,
  input  logic [filter_pkg::LANE_W-1:0] cfg_lane,
  input  filter_pkg::filter_cfg_t     cfg_in,
  input  logic                        in_valid,
  input  logic [filter_pkg::LANE_W-1:0] in_lane,
  input  filter_pkg::engine_packet_t  in_pkt,
  filter_lane_if.feed                 lanes [filter_pkg::NUM_LANES]
);
  import filter_pkg::*;

  filter_cfg_t          cfg_q [NUM_LANES];
  engine_packet_t       pkt_q;
  logic [NUM_LANES-1:0] pkt_valid_q;
  logic [NUM_LANES-1:0] accept;

  // Occupancy tracking per lane
  logic [NUM_LANES-1:0]  done_pipe [KERNEL_LATENCY];
  logic [INFLIGHT_W-1:0] inflight_cnt [NUM_LANES];

  assign accept = in_valid ? (NUM_LANES'(1) << in_lane) : '0;

  // --------------------
  // Configuration bank and packet register
  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        cfg_q[l] <= '0;
      end
      pkt_valid_q <= '0;
    end else begin
      if (cfg_wr) begin
        cfg_q[cfg_lane] <= cfg_in;
      end
      pkt_valid_q <= accept;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (in_valid) begin
      pkt_q <= in_pkt;
    end
  end

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    assign lanes[g].pkt_valid = pkt_valid_q[g];
    assign lanes[g].pkt       = pkt_q;
    assign lanes[g].cfg       = cfg_q[g];
  end

  // --------------------
  // In-flight count, a packet leaves when its lane raises res_valid
  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      for (int s = 0; s < KERNEL_LATENCY; s++) begin
        done_pipe[s] <= '0;
      end
      for (int l = 0; l < NUM_LANES; l++) begin
        inflight_cnt[l] <= '0;
      end
    end else begin
      done_pipe[0] <= pkt_valid_q;
      for (int s = 1; s < KERNEL_LATENCY; s++) begin
        done_pipe[s] <= done_pipe[s-1];
      end
      for (int l = 0; l < NUM_LANES; l++) begin
        inflight_cnt[l] <= inflight_cnt[l] + INFLIGHT_W'(accept[l])
                         - INFLIGHT_W'(done_pipe[KERNEL_LATENCY-1][l]);
      end
    end
  end

  // Reconfiguring a busy lane is undefined
  assert property (@(posedge ap_clk) disable iff (!rst_n)
    cfg_wr |-> inflight_cnt[cfg_lane] == '0)
    else $error("cfg_wr to lane %0d with packets in flight", cfg_lane);

endmodule : filter_dispatch

// File: verilog/filter_cond_kernel.sv
// One filter lane with three stages: operand select, ALU, output register
// Its configuration is sampled together with the packet in the first stage
`timescale 1ns/1ps

module filter_cond_kernel (
  input  logic          ap_clk,
  input  logic          rst_n,
  filter_lane_if.kernel lane
);
  import filter_pkg::*;

  // Stage 1
  engine_packet_t        ops_d;
  engine_packet_t        org_d;
  engine_packet_t        ops_q;
  engine_packet_t        org_q;
  filter_op_e            op_q;
  logic                  eq_q;
  logic [NUM_FIELDS-1:0] fmask1_q;
  logic                  s1_valid;

  // Stage 2
  logic [NUM_FIELDS-1:0] pair_eq;
  logic [NUM_FIELDS-1:0] pair_gt;
  logic [NUM_FIELDS-1:0] pair_lt;
  engine_packet_t        res_d;
  logic [NUM_FIELDS-1:0] cmp_d;
  engine_packet_t        res_q;
  logic [NUM_FIELDS-1:0] cmp_q;
  logic [NUM_FIELDS-1:0] fmask2_q;
  logic                  s2_valid;

  // Stage 3
  engine_packet_t        out_q;
  logic                  pass_q;
  logic                  s3_valid;

  // --------------------
  // Operand select
  always_comb begin
    for (int i = 0; i < NUM_FIELDS; i++) begin
      org_d.field[i]       = lane.pkt.field[i];
      org_d.field_state[i] = lane.pkt.field_state[i];
      ops_d.field[i]       = '0;
      ops_d.field_state[i] = SEQUENCE_INVALID;
      for (int j = 0; j < NUM_FIELDS; j++) begin
        if (lane.cfg.ops_mask[i][j]) begin
          org_d.field[i]       = lane.pkt.field[j];
          org_d.field_state[i] = lane.pkt.field_state[j];
          ops_d.field[i]       = lane.pkt.field[j];
          ops_d.field_state[i] = lane.pkt.field_state[j];
        end
      end
      // Constant overrides the routed field
      if (lane.cfg.const_mask[i]) begin
        ops_d.field[i]       = lane.cfg.const_value;
        ops_d.field_state[i] = SEQUENCE_RUNNING;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    ops_q    <= ops_d;
    org_q    <= org_d;
    op_q     <= lane.cfg.filter_operation;
    eq_q     <= lane.cfg.equal_flag;
    fmask1_q <= lane.cfg.filter_mask;
  end

  // --------------------
  // ALU
  // Each slot is compared with the next one, the last wraps to slot 0
  for (genvar i = 0; i < NUM_FIELDS; i++) begin : g_pair
    assign pair_eq[i] = ops_q.field[i] == ops_q.field[(i + 1) % NUM_FIELDS];
    assign pair_gt[i] = (ops_q.field[i] > ops_q.field[(i + 1) % NUM_FIELDS])
                      | (eq_q & pair_eq[i]);
    assign pair_lt[i] = (ops_q.field[i] < ops_q.field[(i + 1) % NUM_FIELDS])
                      | (eq_q & pair_eq[i]);
  end

  always_comb begin
    res_d = org_q;
    cmp_d = '1;
    case (op_q)
      FILTER_NOP:    res_d = ops_q;
      FILTER_GT:     cmp_d = pair_gt;
      FILTER_LT:     cmp_d = pair_lt;
      FILTER_EQ:     cmp_d = pair_eq;
      FILTER_NOT_EQ: cmp_d = ~pair_eq;
      FILTER_GT_TERN, FILTER_LT_TERN: begin
        res_d.field = ops_q.field;
        // Swap the first two operands unless the condition holds
        if ((op_q == FILTER_GT_TERN) ? !pair_gt[0] : !pair_lt[0]) begin
          res_d.field[0] = ops_q.field[1];
          res_d.field[1] = ops_q.field[0];
        end
      end
      FILTER_EQ_TERN, FILTER_NOT_EQ_TERN: begin
        res_d.field = ops_q.field;
        // Swap first and last operand when the condition holds
        if ((op_q == FILTER_EQ_TERN) ? pair_eq[0] : !pair_eq[0]) begin
          res_d.field[0]            = ops_q.field[NUM_FIELDS-1];
          res_d.field[NUM_FIELDS-1] = ops_q.field[0];
        end
      end
      default: res_d = org_q;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    res_q    <= res_d;
    cmp_q    <= cmp_d;
    fmask2_q <= fmask1_q;
  end

  // --------------------
  // Output register
  always_ff @(posedge ap_clk) begin
    out_q  <= res_q;
    pass_q <= &(cmp_q | ~fmask2_q);
  end

  // Valid travels alongside the data
  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      s1_valid <= lane.pkt_valid;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  assign lane.res_valid = s3_valid;
  assign lane.res       = out_q;
  assign lane.res_pass  = pass_q;

  for (genvar i = 0; i < NUM_FIELDS; i++) begin : g_row_chk
    assert property (@(posedge ap_clk) disable iff (!rst_n)
      lane.pkt_valid |-> $onehot0(lane.cfg.ops_mask[i]))
      else $error("ops_mask row %0d selects more than one field", i);
  end

endmodule : filter_cond_kernel

// File: verilog/filter_collect.sv
// Merges the lane results into one registered output stream
// Relies on equal lane latency so that at most one lane is valid per cycle
`timescale 1ns/1ps

module filter_collect (
  input  logic                          ap_clk,
  input  logic                          rst_n,
  filter_lane_if.drain                  lanes [filter_pkg::NUM_LANES],
  output logic                          out_valid,
  output logic [filter_pkg::LANE_W-1:0] out_lane,
  output filter_pkg::engine_packet_t    out_pkt,
  output logic                          out_pass
);
  import filter_pkg::*;

  logic [NUM_LANES-1:0] valid_vec;
  logic [NUM_LANES-1:0] pass_vec;
  engine_packet_t       res_arr [NUM_LANES];
  logic [LANE_W-1:0]    sel;

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_gather
    assign valid_vec[g] = lanes[g].res_valid;
    assign pass_vec[g]  = lanes[g].res_pass;
    assign res_arr[g]   = lanes[g].res;
  end

  // Index of the valid lane
  always_comb begin
    sel = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (valid_vec[l]) begin
        sel = LANE_W'(l);
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= |valid_vec;
    end
  end

  always_ff @(posedge ap_clk) begin
    out_lane <= sel;
    out_pkt  <= res_arr[sel];
    out_pass <= pass_vec[sel];
  end

  assert property (@(posedge ap_clk) disable iff (!rst_n) $onehot0(valid_vec))
    else $error("several lanes valid at once %b", valid_vec);

endmodule : filter_collect

// File: verilog/filter_engine_top.sv
// Top level of the condition-filter stage with flat ports
// Field i sits at bits [i*FIELD_W +: FIELD_W], ops_mask row i at [i*NUM_FIELDS +: NUM_FIELDS]
`timescale 1ns/1ps

module filter_engine_top (
  input  logic                                                ap_clk,
  input  logic                                                rst_n,
  input  logic                                                cfg_wr,
  input  logic [filter_pkg::LANE_W-1:0]                       cfg_lane,
  input  logic [filter_pkg::NUM_FIELDS-1:0]                   cfg_const_mask,
  input  logic [filter_pkg::NUM_FIELDS*filter_pkg::NUM_FIELDS-1:0] cfg_ops_mask,
  input  logic [filter_pkg::FIELD_W-1:0]                      cfg_const_value,
  input  logic [filter_pkg::NUM_FIELDS-1:0]                   cfg_filter_mask,
  input  logic [3:0]                                          cfg_filter_operation,
  input  logic                                                cfg_equal_flag,
  input  logic                                                in_valid,
  input  logic [filter_pkg::LANE_W-1:0]                       in_lane,
  input  logic [filter_pkg::NUM_FIELDS*filter_pkg::FIELD_W-1:0] in_field,
  input  logic [filter_pkg::NUM_FIELDS*2-1:0]                 in_field_state,
  output logic                                                out_valid,
  output logic [filter_pkg::LANE_W-1:0]                       out_lane,
  output logic [filter_pkg::NUM_FIELDS*filter_pkg::FIELD_W-1:0] out_field,
  output logic [filter_pkg::NUM_FIELDS*2-1:0]                 out_field_state,
  output logic                                                out_pass
);
  import filter_pkg::*;

  filter_cfg_t    cfg_in;
  engine_packet_t in_pkt;
  engine_packet_t out_pkt;

  filter_lane_if lanes [NUM_LANES] ();

  // --------------------
  // Flat ports to structs
  always_comb begin
    cfg_in.const_mask       = cfg_const_mask;
    cfg_in.ops_mask         = cfg_ops_mask;
    cfg_in.const_value      = cfg_const_value;
    cfg_in.filter_mask      = cfg_filter_mask;
    cfg_in.filter_operation = filter_op_e'(cfg_filter_operation);
    cfg_in.equal_flag       = cfg_equal_flag;
    in_pkt.field            = in_field;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      in_pkt.field_state[i] = field_state_e'(in_field_state[2*i +: 2]);
    end
  end

  always_comb begin
    out_field = out_pkt.field;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      out_field_state[2*i +: 2] = out_pkt.field_state[i];
    end
  end

  // --------------------
  // Dispatcher, lanes, collector
  filter_dispatch u_dispatch (
    .ap_clk   (ap_clk),
    .rst_n    (rst_n),
    .cfg_wr   (cfg_wr),
    .cfg_lane (cfg_lane),
    .cfg_in   (cfg_in),
    .in_valid (in_valid),
    .in_lane  (in_lane),
    .in_pkt   (in_pkt),
    .lanes    (lanes)
  );

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_kernel
    filter_cond_kernel u_kernel (
      .ap_clk (ap_clk),
      .rst_n  (rst_n),
      .lane   (lanes[g])
    );
  end

  filter_collect u_collect (
    .ap_clk    (ap_clk),
    .rst_n     (rst_n),
    .lanes     (lanes),
    .out_valid (out_valid),
    .out_lane  (out_lane),
    .out_pkt   (out_pkt),
    .out_pass  (out_pass)
  );

endmodule : filter_engine_top

// File: tb/filter_ref.svh
// Reference model of one filter lane, included inside the testbench module
// filter_model returns the expected packet and sets pass from a lane config and a packet
`ifndef FILTER_REF_SVH
`define FILTER_REF_SVH

function automatic engine_packet_t filter_model(input filter_cfg_t cfg,
                                                input engine_packet_t pkt,
                                                output logic pass);
  engine_packet_t        opnd;
  engine_packet_t        orig;
  engine_packet_t        outp;
  logic [FIELD_W-1:0]    a;
  logic [FIELD_W-1:0]    b;
  logic                  cond;
  int                    src;

  // Operand and original copies
  for (int i = 0; i < NUM_FIELDS; i++) begin
    src = -1;
    for (int j = 0; j < NUM_FIELDS; j++) begin
      if (cfg.ops_mask[i][j]) begin
        src = j;
      end
    end
    if (src < 0) begin
      orig.field[i]       = pkt.field[i];
      orig.field_state[i] = pkt.field_state[i];
      opnd.field[i]       = '0;
      opnd.field_state[i] = SEQUENCE_INVALID;
    end else begin
      orig.field[i]       = pkt.field[src];
      orig.field_state[i] = pkt.field_state[src];
      opnd.field[i]       = pkt.field[src];
      opnd.field_state[i] = pkt.field_state[src];
    end
    if (cfg.const_mask[i]) begin
      opnd.field[i]       = cfg.const_value;
      opnd.field_state[i] = SEQUENCE_RUNNING;
    end
  end

  // Pass flag, only plain compares can clear it
  pass = 1'b1;
  for (int i = 0; i < NUM_FIELDS; i++) begin
    a = opnd.field[i];
    b = opnd.field[(i + 1) % NUM_FIELDS];
    case (cfg.filter_operation)
      FILTER_GT:     cond = cfg.equal_flag ? (a >= b) : (a > b);
      FILTER_LT:     cond = cfg.equal_flag ? (a <= b) : (a < b);
      FILTER_EQ:     cond = (a == b);
      FILTER_NOT_EQ: cond = (a != b);
      default:       cond = 1'b1;
    endcase
    if (cfg.filter_mask[i] && !cond) begin
      pass = 1'b0;
    end
  end

  outp = orig;
  a    = opnd.field[0];
  b    = opnd.field[1];
  case (cfg.filter_operation)
    FILTER_NOP: outp = opnd;
    FILTER_GT_TERN, FILTER_LT_TERN: begin
      outp.field = opnd.field;
      if (cfg.filter_operation == FILTER_GT_TERN) begin
        cond = cfg.equal_flag ? (a >= b) : (a > b);
      end else begin
        cond = cfg.equal_flag ? (a <= b) : (a < b);
      end
      if (!cond) begin
        outp.field[0] = b;
        outp.field[1] = a;
      end
    end
    FILTER_EQ_TERN, FILTER_NOT_EQ_TERN: begin
      outp.field = opnd.field;
      cond = (a == b);
      if (cfg.filter_operation == FILTER_NOT_EQ_TERN) begin
        cond = !cond;
      end
      if (cond) begin
        outp.field[0]            = opnd.field[NUM_FIELDS-1];
        outp.field[NUM_FIELDS-1] = a;
      end
    end
    default: outp = orig;
  endcase
  return outp;
endfunction

`endif

// File: tb/filter_tb.sv
// Testbench for the condition-filter stage, every output is checked against a reference model
// Built and run by the Makefile with Verilator
`timescale 1ns/1ps

module filter_tb;
  import filter_pkg::*;

  `include "filter_ref.svh"

  localparam int CLK_HALF       = 20;
  localparam int RESET_CYCLES   = 8;
  localparam int DRIVE_DELAY    = 2;
  localparam int PIPE_LATENCY   = KERNEL_LATENCY + 2;
  localparam int CMP_PKTS       = 40;
  localparam int TERN_PKTS      = 40;
  localparam int ROUTE_PKTS     = 40;
  localparam int BURST_PKTS     = 64;
  localparam int TOTAL_PKTS     = 1 + 2 * CMP_PKTS + TERN_PKTS + ROUTE_PKTS + BURST_PKTS;
  localparam int NUM_CFG_WRITES = 5 * NUM_LANES;
  localparam int NUM_DRAINS     = 6;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_CFG_WRITES + TOTAL_PKTS
                                + NUM_DRAINS * (PIPE_LATENCY + 1) + 50;
  localparam int CHK_W          = NUM_FIELDS * FIELD_W;

  typedef struct {
    logic [LANE_W-1:0] lane;
    engine_packet_t    pkt;
    logic              pass;
    int                cycle;
  } expect_t;

  logic                             ap_clk;
  logic                             rst_n;
  logic                             cfg_wr;
  logic [LANE_W-1:0]                cfg_lane;
  logic [NUM_FIELDS-1:0]            cfg_const_mask;
  logic [NUM_FIELDS*NUM_FIELDS-1:0] cfg_ops_mask;
  logic [FIELD_W-1:0]               cfg_const_value;
  logic [NUM_FIELDS-1:0]            cfg_filter_mask;
  logic [3:0]                       cfg_filter_operation;
  logic                             cfg_equal_flag;
  logic                             in_valid;
  logic [LANE_W-1:0]                in_lane;
  logic [NUM_FIELDS*FIELD_W-1:0]    in_field;
  logic [NUM_FIELDS*2-1:0]          in_field_state;
  logic                             out_valid;
  logic [LANE_W-1:0]                out_lane;
  logic [NUM_FIELDS*FIELD_W-1:0]    out_field;
  logic [NUM_FIELDS*2-1:0]          out_field_state;
  logic                             out_pass;

  expect_t     exp_q[$];
  filter_cfg_t cfg_shadow [NUM_LANES];
  int          cycle_cnt = 0;

  filter_engine_top u_dut (
    .ap_clk               (ap_clk),
    .rst_n                (rst_n),
    .cfg_wr               (cfg_wr),
    .cfg_lane             (cfg_lane),
    .cfg_const_mask       (cfg_const_mask),
    .cfg_ops_mask         (cfg_ops_mask),
    .cfg_const_value      (cfg_const_value),
    .cfg_filter_mask      (cfg_filter_mask),
    .cfg_filter_operation (cfg_filter_operation),
    .cfg_equal_flag       (cfg_equal_flag),
    .in_valid             (in_valid),
    .in_lane              (in_lane),
    .in_field             (in_field),
    .in_field_state       (in_field_state),
    .out_valid            (out_valid),
    .out_lane             (out_lane),
    .out_field            (out_field),
    .out_field_state      (out_field_state),
    .out_pass             (out_pass)
  );

  initial begin
    ap_clk = 1'b0;
  end

  always #CLK_HALF ap_clk = ~ap_clk;

  // --------------------
  // Helpers
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [CHK_W-1:0] exp_v,
                             input logic [CHK_W-1:0] act_v);
    assert (act_v === exp_v)
      else report_failure($sformatf("Fail %s expected %0h got %0h", name, exp_v, act_v));
  endtask

  function automatic logic [2*NUM_FIELDS-1:0] flat_states(input engine_packet_t p);
    logic [2*NUM_FIELDS-1:0] s;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      s[2*i +: 2] = p.field_state[i];
    end
    return s;
  endfunction

  // Optionally copies one field onto its neighbour to force equal operands
  function automatic engine_packet_t random_packet(input bit force_eq);
    engine_packet_t p;
    int             k;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      p.field[i]       = $urandom();
      p.field_state[i] = field_state_e'($urandom_range(0, 2));
    end
    if (force_eq) begin
      k = $urandom_range(0, NUM_FIELDS - 1);
      p.field[(k + 1) % NUM_FIELDS] = p.field[k];
    end
    return p;
  endfunction

  // Identity routing, or random constants and rows where routed is set
  function automatic filter_cfg_t make_cfg(input filter_op_e op, input logic eq,
                                           input bit routed);
    filter_cfg_t c;
    c.const_mask  = routed ? NUM_FIELDS'($urandom()) : '0;
    c.const_value = $urandom();
    for (int i = 0; i < NUM_FIELDS; i++) begin
      if (!routed) begin
        c.ops_mask[i] = NUM_FIELDS'(1) << i;
      end else if ($urandom_range(0, 3) == 0) begin
        c.ops_mask[i] = '0;
      end else begin
        c.ops_mask[i] = NUM_FIELDS'(1) << $urandom_range(0, NUM_FIELDS - 1);
      end
    end
    c.filter_mask      = NUM_FIELDS'($urandom());
    c.filter_operation = op;
    c.equal_flag       = eq;
    return c;
  endfunction

  task automatic write_config(input logic [LANE_W-1:0] lane, input filter_cfg_t c);
    cfg_shadow[lane]     = c;
    cfg_wr               = 1'b1;
    cfg_lane             = lane;
    cfg_const_mask       = c.const_mask;
    cfg_ops_mask         = c.ops_mask;
    cfg_const_value      = c.const_value;
    cfg_filter_mask      = c.filter_mask;
    cfg_filter_operation = c.filter_operation;
    cfg_equal_flag       = c.equal_flag;
    @(posedge ap_clk);
    #DRIVE_DELAY;
    cfg_wr = 1'b0;
  endtask

  // Pushes the model result, then holds the packet for one edge
  task automatic send_packet(input logic [LANE_W-1:0] lane, input engine_packet_t p);
    expect_t e;
    logic    pass;
    e.lane  = lane;
    e.pkt   = filter_model(cfg_shadow[lane], p, pass);
    e.pass  = pass;
    e.cycle = cycle_cnt;
    exp_q.push_back(e);
    in_valid       = 1'b1;
    in_lane        = lane;
    in_field       = p.field;
    in_field_state = flat_states(p);
    @(posedge ap_clk);
    #DRIVE_DELAY;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain();
    do begin
      @(posedge ap_clk);
    end while (exp_q.size() != 0);
    #DRIVE_DELAY;
  endtask

  // --------------------
  // Cycle count and timeout
  always @(posedge ap_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_failure("Timeout, the expected outputs did not arrive in time");
    end
  end

  // --------------------
  // Output checks, sampled on the falling edge
  // Latency is checked per packet, so a burst keeps out_valid high without gaps
  always @(negedge ap_clk) begin : compare_outputs
    expect_t e;
    if (!rst_n) begin
      if (cycle_cnt > 0) begin
        assert (out_valid === 1'b0)
          else report_failure("out_valid went high during reset");
      end
    end else if (out_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        report_failure("out_valid went high with no packet expected");
      end else begin
        e = exp_q.pop_front();
        assert (cycle_cnt == e.cycle + PIPE_LATENCY)
          else report_failure($sformatf("Packet sent at cycle %0d came out at cycle %0d",
                                        e.cycle, cycle_cnt));
        check_value("out_lane", CHK_W'(e.lane), CHK_W'(out_lane));
        check_value("out_field", CHK_W'(e.pkt.field), CHK_W'(out_field));
        check_value("out_field_state", CHK_W'(flat_states(e.pkt)), CHK_W'(out_field_state));
        check_value("out_pass", CHK_W'(e.pass), CHK_W'(out_pass));
      end
    end
  end

  // --------------------
  // Stimulus
  initial begin : stimulus
    void'($urandom(43));
    rst_n                = 1'b0;
    cfg_wr               = 1'b0;
    cfg_lane             = '0;
    cfg_const_mask       = '0;
    cfg_ops_mask         = '0;
    cfg_const_value      = '0;
    cfg_filter_mask      = '0;
    cfg_filter_operation = '0;
    cfg_equal_flag       = 1'b0;
    in_valid             = 1'b0;
    in_lane              = '0;
    in_field             = '0;
    in_field_state       = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      cfg_shadow[l] = '0;
    end
    repeat (RESET_CYCLES) @(posedge ap_clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;

    // Reset configuration is NOP with every row empty
    send_packet('0, random_packet(1'b0));
    wait_drain();

    // Plain compares, without and with equal_flag
    for (int eq = 0; eq < 2; eq++) begin
      for (int l = 0; l < NUM_LANES; l++) begin
        write_config(LANE_W'(l), make_cfg(filter_op_e'(4'(int'(FILTER_GT) + l)), eq[0], 1'b0));
      end
      for (int n = 0; n < CMP_PKTS; n++) begin
        send_packet(LANE_W'($urandom_range(0, NUM_LANES - 1)), random_packet(n % 3 == 0));
      end
      wait_drain();
    end

    // Ternary swaps
    for (int l = 0; l < NUM_LANES; l++) begin
      write_config(LANE_W'(l), make_cfg(filter_op_e'(4'(int'(FILTER_GT_TERN) + l)),
                                        1'($urandom_range(0, 1)), 1'b0));
    end
    for (int n = 0; n < TERN_PKTS; n++) begin
      send_packet(LANE_W'($urandom_range(0, NUM_LANES - 1)), random_packet(n % 2 == 0));
    end
    wait_drain();

    // Routing under NOP, last lane with an undefined code
    for (int l = 0; l < NUM_LANES - 1; l++) begin
      write_config(LANE_W'(l), make_cfg(FILTER_NOP, 1'b0, 1'b1));
    end
    write_config(LANE_W'(NUM_LANES - 1),
                 make_cfg(filter_op_e'(4'($urandom_range(9, 15))), 1'b0, 1'b1));
    for (int n = 0; n < ROUTE_PKTS; n++) begin
      send_packet(LANE_W'($urandom_range(0, NUM_LANES - 1)), random_packet(1'b0));
    end
    wait_drain();

    // Back-to-back burst over random operations and lanes
    for (int l = 0; l < NUM_LANES; l++) begin
      write_config(LANE_W'(l), make_cfg(filter_op_e'(4'($urandom_range(0, 15))),
                                        1'($urandom_range(0, 1)), 1'b1));
    end
    for (int n = 0; n < BURST_PKTS; n++) begin
      send_packet(LANE_W'($urandom_range(0, NUM_LANES - 1)), random_packet(n % 4 == 0));
    end

    // Last packet leaves the pipeline a fixed latency after its input cycle
    repeat (PIPE_LATENCY + 1) @(posedge ap_clk);

    if (exp_q.size() != 0) begin
      report_failure("Packets were still expected at the end of the run");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule : filter_tb

// File: verilog.f
+incdir+tb
verilog/filter_pkg.sv
verilog/filter_lane_if.sv
verilog/filter_dispatch.sv
verilog/filter_cond_kernel.sv
verilog/filter_collect.sv
verilog/filter_engine_top.sv
tb/filter_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= filter_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
